// File: Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_req_if.sv
  - design/dcache_miss_if.sv
  - design/dcache_tlb.sv
  - design/dcache_access_queue.sv
  - design/dcache_bank.sv
  - design/dcache_mem_port.sv
  - design/dcache_top.sv
  - target: test
    files:
      - testbench/tb_dcache.sv

// File: build.f
design/dcache_pkg.sv
design/dcache_req_if.sv
design/dcache_miss_if.sv
design/dcache_tlb.sv
design/dcache_access_queue.sv
design/dcache_bank.sv
design/dcache_mem_port.sv
design/dcache_top.sv
testbench/tb_dcache.sv

// File: design/dcache_access_queue.sv
`timescale 1ns/1ps

module dcache_access_queue
   import dcache_pkg::*;
#(
   parameter int AQ_DEPTH = 4
) (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                rd_push_i,
   input  logic [PADDR_W-1:0]  rd_paddr_i,
   input  logic [ID_W-1:0]     rd_id_i,
   input  logic                wb_push_i,
   input  logic [PADDR_W-1:0]  wb_paddr_i,
   input  logic [LINE_W-1:0]   wb_data_i,
   output logic                rdaq_full_o,
   output logic                wbaq_full_o,
   output logic                aq_empty_o,
   dcache_req_if.source        req
);

   localparam int PTR_W   = $clog2(AQ_DEPTH);
   localparam int ENTRY_W = PADDR_W + ID_W + LINE_W;

   // Index 0 is the read queue, index 1 the write-back queue
   logic [1:0]          push;
   logic [1:0]          pop;
   logic [1:0]          full;
   logic [1:0]          empty;
   logic [ENTRY_W-1:0]  wr_entry [2];
   logic [ENTRY_W-1:0]  head [2];
   logic [ENTRY_W-1:0]  head_sel;
   logic                sel_wb;

   assign push        = {wb_push_i, rd_push_i};
   assign wr_entry[0] = {rd_paddr_i, rd_id_i, {LINE_W{1'b0}}};
   assign wr_entry[1] = {wb_paddr_i, {ID_W{1'b0}}, wb_data_i};

   for (genvar q = 0; q < 2; q++) begin : g_fifo
      logic [ENTRY_W-1:0]  mem_q [AQ_DEPTH];
      logic [PTR_W-1:0]    wr_ptr_q;
      logic [PTR_W-1:0]    rd_ptr_q;
      logic [PTR_W:0]      count_q;

      always_ff @(posedge clk or negedge rst_n_i) begin
         if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
         end else begin
            if (push[q]) begin
               wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop[q]) begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(push[q]) - (PTR_W+1)'(pop[q]);
         end
      end

      always_ff @(posedge clk) begin
         if (push[q]) begin
            mem_q[wr_ptr_q] <= wr_entry[q];
         end
      end

      assign head[q]  = mem_q[rd_ptr_q];
      assign full[q]  = (count_q == (PTR_W+1)'(AQ_DEPTH));
      assign empty[q] = (count_q == '0);

      // Requestors must respect the full flag
      a_no_push_full: assert property (
         @(posedge clk) disable iff (!rst_n_i) push[q] |-> !full[q]
      );
   end

   // Write-back first
   assign sel_wb   = !empty[1];
   assign head_sel = sel_wb ? head[1] : head[0];

   assign req.valid = !(empty[0] && empty[1]);
   assign req.op    = sel_wb ? OP_WRITE : OP_READ;
   assign req.paddr = head_sel[ENTRY_W-1 -: PADDR_W];
   assign req.id    = head_sel[LINE_W +: ID_W];
   assign req.wdata = head_sel[LINE_W-1:0];

   assign pop[0] = req.pop && !sel_wb;
   assign pop[1] = req.pop && sel_wb;

   assign rdaq_full_o = full[0];
   assign wbaq_full_o = full[1];
   assign aq_empty_o  = empty[0] && empty[1];

endmodule

// File: design/dcache_bank.sv
`timescale 1ns/1ps

module dcache_bank
   import dcache_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n_i,
   dcache_req_if.sink         req,
   dcache_miss_if.bank        mem,
   output logic               resp_valid_o,
   output logic [ID_W-1:0]    resp_id_o,
   output logic [LINE_W-1:0]  resp_data_o
);

   localparam int LINES = 2 ** INDEX_W;

   bank_state_e          state_q;
   logic [LINES-1:0]     line_valid_q;
   logic [TAG_W-1:0]     tag_q [LINES];
   logic [LINE_W-1:0]    data_q [LINES];

   // Saved miss context
   logic [INDEX_W-1:0]   miss_index_q;
   logic [TAG_W-1:0]     miss_tag_q;
   logic [ID_W-1:0]      miss_id_q;

   logic [INDEX_W-1:0]   req_index;
   logic [TAG_W-1:0]     req_tag;
   logic                 hit;
   logic                 rd_pop;
   logic                 wr_pop;
   logic                 fill;

   assign req_index = req.paddr[OFFSET_W +: INDEX_W];
   assign req_tag   = req.paddr[PADDR_W-1 -: TAG_W];
   assign hit       = line_valid_q[req_index] && (tag_q[req_index] == req_tag);

   // No pops while a miss is outstanding
   assign req.pop = req.valid && (state_q == ST_IDLE);
   assign rd_pop  = req.pop && (req.op == OP_READ);
   assign wr_pop  = req.pop && (req.op == OP_WRITE);
   assign fill    = (state_q == ST_MISS_WAIT) && mem.fill_valid;

   assign mem.miss      = rd_pop && !hit;
   assign mem.miss_line = req.paddr[PADDR_W-1:OFFSET_W];

   // Every write also goes out to memory
   assign mem.wr      = wr_pop;
   assign mem.wr_addr = req.paddr;
   assign mem.wr_data = req.wdata;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         line_valid_q <= '0;
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= (rd_pop && hit) || fill;
         if (mem.miss) begin
            state_q <= ST_MISS_WAIT;
         end else if (fill) begin
            state_q <= ST_IDLE;
         end
         if (wr_pop) begin
            line_valid_q[req_index] <= 1'b1;
         end
         if (fill) begin
            line_valid_q[miss_index_q] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      // Full-line write allocates
      if (wr_pop) begin
         tag_q[req_index]  <= req_tag;
         data_q[req_index] <= req.wdata;
      end
      if (fill) begin
         tag_q[miss_index_q]  <= miss_tag_q;
         data_q[miss_index_q] <= mem.fill_data;
      end
      if (mem.miss) begin
         miss_index_q <= req_index;
         miss_tag_q   <= req_tag;
         miss_id_q    <= req.id;
      end
      if (rd_pop && hit) begin
         resp_id_o   <= req.id;
         resp_data_o <= data_q[req_index];
      end else if (fill) begin
         resp_id_o   <= miss_id_q;
         resp_data_o <= mem.fill_data;
      end
   end

   // Memory answers land only while a miss waits
   a_fill_in_miss_wait: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      mem.fill_valid |-> state_q == ST_MISS_WAIT
   );

endmodule

// File: design/dcache_mem_port.sv
`timescale 1ns/1ps

module dcache_mem_port
   import dcache_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst_n_i,
   dcache_miss_if.port                  mem,
   output logic                         fill_req_o,
   output logic [PADDR_W-OFFSET_W-1:0]  fill_line_o,
   input  logic                         fill_valid_i,
   input  logic [LINE_W-1:0]            fill_data_i,
   output logic                         mem_wr_valid_o,
   output logic [PADDR_W-1:0]           mem_wr_addr_o,
   output logic [LINE_W-1:0]            mem_wr_data_o
);

   // Stray answers never reach the bank
   assign mem.fill_valid = fill_valid_i && fill_req_o;
   assign mem.fill_data  = fill_data_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fill_req_o     <= 1'b0;
         mem_wr_valid_o <= 1'b0;
      end else begin
         if (mem.miss) begin
            fill_req_o <= 1'b1;
         end else if (mem.fill_valid) begin
            fill_req_o <= 1'b0;
         end
         mem_wr_valid_o <= mem.wr;
      end
   end

   always_ff @(posedge clk) begin
      if (mem.miss) begin
         fill_line_o <= mem.miss_line;
      end
      if (mem.wr) begin
         mem_wr_addr_o <= mem.wr_addr;
         mem_wr_data_o <= mem.wr_data;
      end
   end

   // Memory answers only a pending request
   a_fill_when_req: assert property (
      @(posedge clk) disable iff (!rst_n_i) fill_valid_i |-> fill_req_o
   );

   // Single outstanding miss
   a_one_miss: assert property (
      @(posedge clk) disable iff (!rst_n_i) mem.miss |-> !fill_req_o
   );

endmodule

// File: design/dcache_miss_if.sv
`timescale 1ns/1ps

interface dcache_miss_if
   import dcache_pkg::*;
();

   logic                         miss;
   logic [PADDR_W-OFFSET_W-1:0]  miss_line;

   logic                         wr;
   logic [PADDR_W-1:0]           wr_addr;
   logic [LINE_W-1:0]            wr_data;

   // Memory answer for the outstanding miss
   logic                         fill_valid;
   logic [LINE_W-1:0]            fill_data;

   modport bank (
      output miss,
      output miss_line,
      output wr,
      output wr_addr,
      output wr_data,
      input  fill_valid,
      input  fill_data
   );

   modport port (
      input  miss,
      input  miss_line,
      input  wr,
      input  wr_addr,
      input  wr_data,
      output fill_valid,
      output fill_data
   );

endinterface

// File: design/dcache_pkg.sv
package dcache_pkg;

   // Address widths
   localparam int VADDR_W       = 32;
   localparam int PADDR_W       = 15;
   localparam int PAGE_OFFSET_W = 12;
   localparam int VPN_W         = VADDR_W - PAGE_OFFSET_W;
   localparam int PFN_W         = PADDR_W - PAGE_OFFSET_W;

   // Cache geometry, 16 lines of 16 bytes
   localparam int LINE_W   = 128;
   localparam int OFFSET_W = 4;
   localparam int INDEX_W  = 4;
   localparam int TAG_W    = PADDR_W - INDEX_W - OFFSET_W;

   // Request id and translation
   localparam int ID_W        = 7;
   localparam int TLB_ENTRIES = 8;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } req_op_e;

   typedef enum logic {
      ST_IDLE,
      ST_MISS_WAIT
   } bank_state_e;

endpackage

// File: design/dcache_req_if.sv
`timescale 1ns/1ps

interface dcache_req_if
   import dcache_pkg::*;
();

   // Head entry of the access queue
   logic                valid;
   req_op_e             op;
   logic [PADDR_W-1:0]  paddr;
   logic [LINE_W-1:0]   wdata;
   logic [ID_W-1:0]     id;

   // Bank takes the head
   logic                pop;

   modport source (
      output valid,
      output op,
      output paddr,
      output wdata,
      output id,
      input  pop
   );

   modport sink (
      input  valid,
      input  op,
      input  paddr,
      input  wdata,
      input  id,
      output pop
   );

endinterface

// File: design/dcache_tlb.sv
`timescale 1ns/1ps

module dcache_tlb
   import dcache_pkg::*;
(
   input  logic [VADDR_W-1:0]                 vaddr_i,
   input  logic                               valid_i,
   input  logic                               is_write_i,
   input  logic [TLB_ENTRIES-1:0][VPN_W-1:0]  tlb_vpn_i,
   input  logic [TLB_ENTRIES-1:0][PFN_W-1:0]  tlb_pfn_i,
   input  logic [TLB_ENTRIES-1:0]             tlb_valid_i,
   input  logic [TLB_ENTRIES-1:0]             tlb_present_i,
   input  logic [TLB_ENTRIES-1:0]             tlb_writable_i,
   output logic                               hit_o,
   output logic [PADDR_W-1:0]                 paddr_o,
   output logic                               miss_o,
   output logic                               pe_o
);

   logic [VPN_W-1:0]        vpn;
   logic [TLB_ENTRIES-1:0]  match;
   logic [PFN_W-1:0]        pfn;
   logic                    present;
   logic                    writable;
   logic                    any_match;
   logic                    prot_err;

   assign vpn = vaddr_i[VADDR_W-1:PAGE_OFFSET_W];

   // Fully associative compare, lowest matching entry wins
   always_comb begin
      match    = '0;
      pfn      = '0;
      present  = 1'b0;
      writable = 1'b0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         match[i] = tlb_valid_i[i] && (tlb_vpn_i[i] == vpn);
         if (match[i]) begin
            pfn      = tlb_pfn_i[i];
            present  = tlb_present_i[i];
            writable = tlb_writable_i[i];
         end
      end
   end

   assign any_match = |match;
   assign prot_err  = !present || (is_write_i && !writable);

   // Exception flags only in the strobe cycle
   assign miss_o = valid_i && !any_match;
   assign pe_o   = valid_i && any_match && prot_err;

   // hit_o is the plain translation result, the caller qualifies it
   assign hit_o   = any_match && !prot_err;
   assign paddr_o = {pfn, vaddr_i[PAGE_OFFSET_W-1:0]};

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
#(
   parameter int AQ_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n_i,
   // Read requestor
   input  logic                               rd_valid_i,
   input  logic [VADDR_W-1:0]                 rd_vaddr_i,
   input  logic [ID_W-1:0]                    rd_id_i,
   // Write-back requestor
   input  logic                               wb_valid_i,
   input  logic [VADDR_W-1:0]                 wb_vaddr_i,
   input  logic [LINE_W-1:0]                  wb_data_i,
   // Shared TLB entries
   input  logic [TLB_ENTRIES-1:0][VPN_W-1:0]  tlb_vpn_i,
   input  logic [TLB_ENTRIES-1:0][PFN_W-1:0]  tlb_pfn_i,
   input  logic [TLB_ENTRIES-1:0]             tlb_valid_i,
   input  logic [TLB_ENTRIES-1:0]             tlb_present_i,
   input  logic [TLB_ENTRIES-1:0]             tlb_writable_i,
   output logic                               tlb_miss_r_o,
   output logic                               tlb_pe_r_o,
   output logic                               tlb_miss_wb_o,
   output logic                               tlb_pe_wb_o,
   // Memory side
   output logic                               fill_req_o,
   output logic [PADDR_W-OFFSET_W-1:0]        fill_line_o,
   input  logic                               fill_valid_i,
   input  logic [LINE_W-1:0]                  fill_data_i,
   output logic                               mem_wr_valid_o,
   output logic [PADDR_W-1:0]                 mem_wr_addr_o,
   output logic [LINE_W-1:0]                  mem_wr_data_o,
   // Response and status
   output logic                               resp_valid_o,
   output logic [ID_W-1:0]                    resp_id_o,
   output logic [LINE_W-1:0]                  resp_data_o,
   output logic                               rdaq_full_o,
   output logic                               wbaq_full_o,
   output logic                               aq_empty_o
);

   logic                rd_hit;
   logic                wb_hit;
   logic [PADDR_W-1:0]  rd_paddr;
   logic [PADDR_W-1:0]  wb_paddr;

   dcache_req_if  req_if ();
   dcache_miss_if miss_if ();

   dcache_tlb u_tlb_rd (
      .vaddr_i        (rd_vaddr_i),
      .valid_i        (rd_valid_i),
      .is_write_i     (1'b0),
      .tlb_vpn_i      (tlb_vpn_i),
      .tlb_pfn_i      (tlb_pfn_i),
      .tlb_valid_i    (tlb_valid_i),
      .tlb_present_i  (tlb_present_i),
      .tlb_writable_i (tlb_writable_i),
      .hit_o          (rd_hit),
      .paddr_o        (rd_paddr),
      .miss_o         (tlb_miss_r_o),
      .pe_o           (tlb_pe_r_o)
   );

   dcache_tlb u_tlb_wb (
      .vaddr_i        (wb_vaddr_i),
      .valid_i        (wb_valid_i),
      .is_write_i     (1'b1),
      .tlb_vpn_i      (tlb_vpn_i),
      .tlb_pfn_i      (tlb_pfn_i),
      .tlb_valid_i    (tlb_valid_i),
      .tlb_present_i  (tlb_present_i),
      .tlb_writable_i (tlb_writable_i),
      .hit_o          (wb_hit),
      .paddr_o        (wb_paddr),
      .miss_o         (tlb_miss_wb_o),
      .pe_o           (tlb_pe_wb_o)
   );

   dcache_access_queue #(
      .AQ_DEPTH (AQ_DEPTH)
   ) u_aq (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rd_push_i   (rd_valid_i && rd_hit),
      .rd_paddr_i  (rd_paddr),
      .rd_id_i     (rd_id_i),
      .wb_push_i   (wb_valid_i && wb_hit),
      .wb_paddr_i  (wb_paddr),
      .wb_data_i   (wb_data_i),
      .rdaq_full_o (rdaq_full_o),
      .wbaq_full_o (wbaq_full_o),
      .aq_empty_o  (aq_empty_o),
      .req         (req_if.source)
   );

   dcache_bank u_bank (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .req          (req_if.sink),
      .mem          (miss_if.bank),
      .resp_valid_o (resp_valid_o),
      .resp_id_o    (resp_id_o),
      .resp_data_o  (resp_data_o)
   );

   dcache_mem_port u_mem_port (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .mem            (miss_if.port),
      .fill_req_o     (fill_req_o),
      .fill_line_o    (fill_line_o),
      .fill_valid_i   (fill_valid_i),
      .fill_data_i    (fill_data_i),
      .mem_wr_valid_o (mem_wr_valid_o),
      .mem_wr_addr_o  (mem_wr_addr_o),
      .mem_wr_data_o  (mem_wr_data_o)
   );

endmodule

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
   import dcache_pkg::*;
();

   localparam int AQ_DEPTH   = 4;
   localparam int CLK_PERIOD = 10;
   localparam int WAIT_LIMIT = 50;
   // Worst case of each test in cycles, in run order
   localparam int TEST_CYCLES = 2 + 3 * 13 + (3 * WAIT_LIMIT + 4) + (2 * WAIT_LIMIT + 6)
                                + (2 * (AQ_DEPTH + 1) * WAIT_LIMIT + 2 * (AQ_DEPTH + 1));

   logic                               clk = 1'b0;
   logic                               rst_n_i;
   logic                               rd_valid_i;
   logic [VADDR_W-1:0]                 rd_vaddr_i;
   logic [ID_W-1:0]                    rd_id_i;
   logic                               wb_valid_i;
   logic [VADDR_W-1:0]                 wb_vaddr_i;
   logic [LINE_W-1:0]                  wb_data_i;
   logic [TLB_ENTRIES-1:0][VPN_W-1:0]  tlb_vpn_i;
   logic [TLB_ENTRIES-1:0][PFN_W-1:0]  tlb_pfn_i;
   logic [TLB_ENTRIES-1:0]             tlb_valid_i;
   logic [TLB_ENTRIES-1:0]             tlb_present_i;
   logic [TLB_ENTRIES-1:0]             tlb_writable_i;
   logic                               tlb_miss_r_o;
   logic                               tlb_pe_r_o;
   logic                               tlb_miss_wb_o;
   logic                               tlb_pe_wb_o;
   logic                               fill_req_o;
   logic [PADDR_W-OFFSET_W-1:0]        fill_line_o;
   logic                               fill_valid_i;
   logic [LINE_W-1:0]                  fill_data_i;
   logic                               mem_wr_valid_o;
   logic [PADDR_W-1:0]                 mem_wr_addr_o;
   logic [LINE_W-1:0]                  mem_wr_data_o;
   logic                               resp_valid_o;
   logic [ID_W-1:0]                    resp_id_o;
   logic [LINE_W-1:0]                  resp_data_o;
   logic                               rdaq_full_o;
   logic                               wbaq_full_o;
   logic                               aq_empty_o;

   int seed         = 32'h6687;
   int errors       = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int wr_strobes   = 0;

   // Memory lines as the testbench expects them
   logic [LINE_W-1:0] mem_model [logic [PADDR_W-OFFSET_W-1:0]];

   dcache_top #(
      .AQ_DEPTH (AQ_DEPTH)
   ) i_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      if (rst_n_i && mem_wr_valid_o) begin
         wr_strobes++;
      end
   end

   task automatic check(input string name, input logic [LINE_W-1:0] got,
                        input logic [LINE_W-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic next_line(output logic [LINE_W-1:0] line);
      line = {$random(seed), $random(seed), $random(seed), $random(seed)};
   endtask

   task automatic end_test(input string name, input int start);
      tests_run++;
      if (errors == start) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - start);
      end
   endtask

   task automatic send_read(input logic [VADDR_W-1:0] vaddr, input logic [ID_W-1:0] id);
      @(negedge clk);
      rd_valid_i = 1'b1;
      rd_vaddr_i = vaddr;
      rd_id_i    = id;
      @(negedge clk);
      rd_valid_i = 1'b0;
   endtask

   task automatic send_wb(input logic [VADDR_W-1:0] vaddr, input logic [LINE_W-1:0] data);
      @(negedge clk);
      wb_valid_i = 1'b1;
      wb_vaddr_i = vaddr;
      wb_data_i  = data;
      @(negedge clk);
      wb_valid_i = 1'b0;
   endtask

   // Polls from the current falling edge until the named output is high
   task automatic wait_for(input string what, output bit seen);
      int n;
      seen = 1'b0;
      for (n = 0; n <= WAIT_LIMIT && !seen; n++) begin
         if (n > 0) begin
            @(negedge clk);
         end
         case (what)
            "fill_req_o":     seen = fill_req_o;
            "resp_valid_o":   seen = resp_valid_o;
            "mem_wr_valid_o": seen = mem_wr_valid_o;
            default:          seen = 1'b0;
         endcase
      end
      if (!seen) begin
         $display("ERROR: %s did not rise within %0d cycles", what, WAIT_LIMIT);
         errors++;
      end
   endtask

   // Answers the pending fill from the memory model, new lines get random data
   task automatic answer_fill(output logic [LINE_W-1:0] data);
      logic [PADDR_W-OFFSET_W-1:0] line;
      line = fill_line_o;
      if (!mem_model.exists(line)) begin
         next_line(data);
         mem_model[line] = data;
      end
      data         = mem_model[line];
      fill_valid_i = 1'b1;
      fill_data_i  = data;
      @(negedge clk);
      fill_valid_i = 1'b0;
   endtask

   task automatic read_expect(input logic [VADDR_W-1:0] vaddr, input logic [ID_W-1:0] id,
                              input logic [LINE_W-1:0] exp_data);
      bit seen;
      send_read(vaddr, id);
      wait_for("resp_valid_o", seen);
      if (seen) begin
         check("resp_id_o", resp_id_o, id);
         check("resp_data_o", resp_data_o, exp_data);
         check("fill_req_o", fill_req_o, 1'b0);
      end
   endtask

   task automatic try_exception(input bit is_wb, input logic [VADDR_W-1:0] vaddr,
                                input logic [3:0] exp_flags);
      logic [3:0] flags;
      int         strobes_before;
      strobes_before = wr_strobes;
      @(negedge clk);
      if (is_wb) begin
         wb_valid_i = 1'b1;
         wb_vaddr_i = vaddr;
      end else begin
         rd_valid_i = 1'b1;
         rd_vaddr_i = vaddr;
      end
      #1;
      flags = {tlb_miss_r_o, tlb_pe_r_o, tlb_miss_wb_o, tlb_pe_wb_o};
      check("tlb exception flags", flags, exp_flags);
      @(negedge clk);
      rd_valid_i = 1'b0;
      wb_valid_i = 1'b0;
      // First look falls right after the strobe edge
      repeat (10) begin
         check("aq_empty_o", aq_empty_o, 1'b1);
         check("resp_valid_o", resp_valid_o, 1'b0);
         check("fill_req_o", fill_req_o, 1'b0);
         @(negedge clk);
      end
      check("mem_wr_valid_o strobes", wr_strobes - strobes_before, 0);
   endtask

   task automatic test_reset();
      int start;
      start = errors;
      check("aq_empty_o", aq_empty_o, 1'b1);
      check("rdaq_full_o", rdaq_full_o, 1'b0);
      check("wbaq_full_o", wbaq_full_o, 1'b0);
      check("resp_valid_o", resp_valid_o, 1'b0);
      check("fill_req_o", fill_req_o, 1'b0);
      check("mem_wr_valid_o", mem_wr_valid_o, 1'b0);
      end_test("reset", start);
   endtask

   task automatic test_exceptions();
      int start;
      start = errors;
      // Flag order is miss_r, pe_r, miss_wb, pe_wb
      try_exception(1'b0, 32'h0005_0010, 4'b1000);
      try_exception(1'b0, 32'h0003_0010, 4'b0100);
      try_exception(1'b1, 32'h0002_0010, 4'b0001);
      end_test("exceptions", start);
   endtask

   task automatic test_read_miss();
      int                  start;
      bit                  seen;
      logic [VADDR_W-1:0]  vaddr;
      logic [PADDR_W-1:0]  paddr;
      logic [LINE_W-1:0]   data;
      start = errors;
      vaddr = 32'h0001_0120;
      paddr = {3'd1, vaddr[PAGE_OFFSET_W-1:0]};
      send_read(vaddr, 7'h05);
      wait_for("fill_req_o", seen);
      if (seen) begin
         check("fill_line_o", fill_line_o, paddr[PADDR_W-1:OFFSET_W]);
         answer_fill(data);
         wait_for("resp_valid_o", seen);
         if (seen) begin
            check("resp_id_o", resp_id_o, 7'h05);
            check("resp_data_o", resp_data_o, data);
         end
         // Same line, other offset
         read_expect(vaddr + 32'h4, 7'h06, data);
      end
      end_test("read miss and fill", start);
   endtask

   task automatic test_write();
      int                  start;
      int                  strobes_before;
      bit                  seen;
      logic [VADDR_W-1:0]  vaddr;
      logic [PADDR_W-1:0]  paddr;
      logic [LINE_W-1:0]   wdata;
      start          = errors;
      vaddr          = 32'h0001_0240;
      paddr          = {3'd1, vaddr[PAGE_OFFSET_W-1:0]};
      strobes_before = wr_strobes;
      next_line(wdata);
      send_wb(vaddr, wdata);
      wait_for("mem_wr_valid_o", seen);
      if (seen) begin
         check("mem_wr_addr_o", mem_wr_addr_o, paddr);
         check("mem_wr_data_o", mem_wr_data_o, wdata);
      end
      mem_model[paddr[PADDR_W-1:OFFSET_W]] = wdata;
      read_expect(vaddr, 7'h07, wdata);
      check("mem_wr_valid_o strobes", wr_strobes - strobes_before, 1);
      end_test("write through", start);
   endtask

   task automatic test_backpressure();
      int                  start;
      bit                  seen;
      logic [VADDR_W-1:0]  vaddr;
      logic [PADDR_W-1:0]  paddr;
      logic [LINE_W-1:0]   data;
      start = errors;
      // The first read blocks the bank, the rest wait in the queue
      for (int i = 0; i <= AQ_DEPTH; i++) begin
         if (i == AQ_DEPTH) begin
            check("rdaq_full_o", rdaq_full_o, 1'b0);
         end
         send_read(32'h0001_0500 + 32'h100 * i, ID_W'(20 + i));
      end
      check("rdaq_full_o", rdaq_full_o, 1'b1);
      for (int i = 0; i <= AQ_DEPTH; i++) begin
         vaddr = 32'h0001_0500 + 32'h100 * i;
         paddr = {3'd1, vaddr[PAGE_OFFSET_W-1:0]};
         wait_for("fill_req_o", seen);
         if (!seen) begin
            break;
         end
         check("fill_line_o", fill_line_o, paddr[PADDR_W-1:OFFSET_W]);
         answer_fill(data);
         wait_for("resp_valid_o", seen);
         if (seen) begin
            check("resp_id_o", resp_id_o, ID_W'(20 + i));
            check("resp_data_o", resp_data_o, data);
         end
      end
      end_test("back-pressure", start);
   endtask

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + 100));
      $display("ERROR: watchdog expired before the tests finished");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      rst_n_i      = 1'b0;
      rd_valid_i   = 1'b0;
      rd_vaddr_i   = '0;
      rd_id_i      = '0;
      wb_valid_i   = 1'b0;
      wb_vaddr_i   = '0;
      wb_data_i    = '0;
      fill_valid_i = 1'b0;
      fill_data_i  = '0;
      tlb_vpn_i    = '0;
      tlb_pfn_i    = '0;
      // Entry 0 writable, entry 1 read-only, entry 2 not present
      tlb_vpn_i[0]   = 20'h00010;
      tlb_pfn_i[0]   = 3'd1;
      tlb_vpn_i[1]   = 20'h00020;
      tlb_pfn_i[1]   = 3'd2;
      tlb_vpn_i[2]   = 20'h00030;
      tlb_pfn_i[2]   = 3'd3;
      tlb_valid_i    = 8'b0000_0111;
      tlb_present_i  = 8'b0000_0011;
      tlb_writable_i = 8'b0000_0001;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      test_reset();
      test_exceptions();
      test_read_miss();
      test_write();
      test_backpressure();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
